// ==== hdl/noc_cfg.svh ====
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

//////////////////////////////////////////////////
// mesh geometry
//////////////////////////////////////////////////

// 4 by 4 mesh
`define NOC_X_NODES 4
`define NOC_Y_NODES 4

// bits per coordinate, enough for 4 columns or rows
`define NOC_COORD_W 2

//////////////////////////////////////////////////
// flit and buffer sizing
//////////////////////////////////////////////////

// one flit word
`define NOC_FLIT_W 16

// flit fifo depth, power of two
`define NOC_FIFO_DEPTH 4

//////////////////////////////////////////////////
// default node position
//////////////////////////////////////////////////

// same node as the route reference
`define NOC_NODE_X 0
`define NOC_NODE_Y 1

`endif

// ==== hdl/noc_flit_pkg.sv ====
`include "noc_cfg.svh"

package noc_flit_pkg;

   //////////////////////////////////////////////////
   // flit type, top two bits of every flit
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      FLIT_BODY      = 2'b00,
      FLIT_TAIL      = 2'b01,
      FLIT_HEADER    = 2'b10,
      // single flit packet, opens and closes at once
      FLIT_HEAD_TAIL = 2'b11
   } flit_kind_e;

   //////////////////////////////////////////////////
   // flit word, two decodings of the same bits
   //////////////////////////////////////////////////

   typedef union packed {
      // header view, carries the destination
      struct packed {
         flit_kind_e                                  kind;
         logic [`NOC_COORD_W-1:0]                     dest_x;
         logic [`NOC_COORD_W-1:0]                     dest_y;
         logic [`NOC_FLIT_W-3-2*`NOC_COORD_W:0]       payload;
      } hdr;
      // body view, all bits below the kind are data
      struct packed {
         flit_kind_e                                  kind;
         logic [`NOC_FLIT_W-3:0]                      payload;
      } body;
   } flit_u;

endpackage

// ==== hdl/noc_port_pkg.sv ====
`include "noc_cfg.svh"

package noc_port_pkg;

   //////////////////////////////////////////////////
   // output port codes
   //////////////////////////////////////////////////

   // code 0 unused
   typedef enum logic [2:0] {
      PORT_LOCAL = 3'd1,
      PORT_EAST  = 3'd2,
      PORT_NORTH = 3'd3,
      PORT_WEST  = 3'd4,
      PORT_SOUTH = 3'd5
   } out_port_e;

   // width of the one-hot port vectors
   // bit i stands for port code i+1
   localparam int NOC_NUM_PORTS = 5;

   //////////////////////////////////////////////////
   // mesh coordinates
   //////////////////////////////////////////////////

   // x grows to the east
   // y grows to the south
   typedef logic [`NOC_COORD_W-1:0] coord_t;

endpackage

// ==== hdl/flit_ingress.sv ====
`timescale 1ns/100ps

`include "noc_cfg.svh"

module flit_ingress import noc_flit_pkg::*; (
   input  logic                                  clk,
   input  logic                                  rst,
   input  flit_u                                 in_flit,
   input  logic                                  in_valid,
   input  logic [$clog2(`NOC_FIFO_DEPTH):0]      fifo_count,
   output logic                                  in_full,
   output logic                                  drop,
   output flit_u                                 stage_flit,
   output logic                                  stage_push
);

   localparam int CNT_W = $clog2(`NOC_FIFO_DEPTH) + 1;

   logic             in_pkt;
   logic             is_open;
   logic             frame_err;
   logic             accept;
   logic [CNT_W:0]   held;

   //////////////////////////////////////////////////
   // framing check
   //////////////////////////////////////////////////

   // header and head_tail start a packet
   assign is_open = (in_flit.hdr.kind == FLIT_HEADER) ||
                    (in_flit.hdr.kind == FLIT_HEAD_TAIL);

   // opener inside a packet, or body/tail outside one
   assign frame_err = is_open ? in_pkt : !in_pkt;

   assign accept = in_valid && !in_full && !frame_err;

   // fifo contents plus the flit waiting in the stage
   assign held = {1'b0, fifo_count} + {{CNT_W{1'b0}}, stage_push};

   // one slot kept back for the flit the sender may already be driving
   assign in_full = (held >= (CNT_W + 1)'(`NOC_FIFO_DEPTH - 1));

   //////////////////////////////////////////////////
   // control state
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         in_pkt     <= 1'b0;
         stage_push <= 1'b0;
         drop       <= 1'b0;
      end else begin
         stage_push <= accept;
         // discarded flit, pulse one cycle later
         drop       <= in_valid && !accept;
         if (accept) begin
            // header opens, tail closes, head_tail leaves it closed
            case (in_flit.hdr.kind)
               FLIT_HEADER: in_pkt <= 1'b1;
               FLIT_TAIL:   in_pkt <= 1'b0;
               default:     in_pkt <= in_pkt;
            endcase
         end
      end
   end

   // staged flit word
   always_ff @(posedge clk) begin
      if (accept) begin
         stage_flit <= in_flit;
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // a flit is either staged or dropped
   a_push_not_drop: assert property (@(posedge clk) disable iff (rst)
      !(stage_push && drop))
      else $error("flit_ingress: stage_push and drop together");

endmodule

// ==== hdl/flit_fifo.sv ====
`timescale 1ns/100ps

`include "noc_cfg.svh"

module flit_fifo import noc_flit_pkg::*; (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  push,
   input  flit_u                                 push_flit,
   input  logic                                  pop,
   output flit_u                                 head_flit,
   output logic                                  empty,
   output logic [$clog2(`NOC_FIFO_DEPTH):0]      count
);

   localparam int DEPTH = `NOC_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = PTR_W + 1;

   flit_u               mem [DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic                full;

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(DEPTH));

   // head is read straight from the array
   assign head_flit = mem[rd_ptr];

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_flit;
      end
   end

   //////////////////////////////////////////////////
   // pointers and occupancy
   //////////////////////////////////////////////////

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + PTR_W'(1);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + PTR_W'(1);
         end
         // push with pop leaves the count alone
         case ({push, pop})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // ingress holds back a slot, so full plus push is a bug upstream
   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      !(push && full))
      else $error("flit_fifo: push while full");

   // steering only pops a valid head
   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      !(pop && empty))
      else $error("flit_fifo: pop while empty");

endmodule

// ==== hdl/xy_route_unit.sv ====
`timescale 1ns/100ps

`include "noc_cfg.svh"

module xy_route_unit import noc_port_pkg::*; (
   input  coord_t     dest_x,
   input  coord_t     dest_y,
   input  coord_t     node_x,
   input  coord_t     node_y,
   output out_port_e  port
);

   // one extra bit for the sign
   logic signed [`NOC_COORD_W:0] xdiff;
   logic signed [`NOC_COORD_W:0] ydiff;

   //////////////////////////////////////////////////
   // offsets from this node
   //////////////////////////////////////////////////

   assign xdiff = $signed({1'b0, dest_x}) - $signed({1'b0, node_x});
   assign ydiff = $signed({1'b0, dest_y}) - $signed({1'b0, node_y});

   //////////////////////////////////////////////////
   // dimension order, x first then y
   //////////////////////////////////////////////////

   always_comb begin
      if (xdiff > 0) begin
         port = PORT_EAST;
      end else if (xdiff < 0) begin
         port = PORT_WEST;
      end else if (ydiff > 0) begin
         // same column, y grows to the south
         port = PORT_SOUTH;
      end else if (ydiff < 0) begin
         port = PORT_NORTH;
      end else begin
         // arrived
         port = PORT_LOCAL;
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // legal code out
   always_comb begin
      assert (port inside {PORT_LOCAL, PORT_EAST, PORT_NORTH, PORT_WEST, PORT_SOUTH})
         else $error("xy_route_unit: illegal port code");
   end

endmodule

// ==== hdl/output_steer.sv ====
`timescale 1ns/100ps

module output_steer import noc_flit_pkg::*, noc_port_pkg::*; (
   input  logic                          clk,
   input  logic                          rst,
   input  flit_u                         head_flit,
   input  logic                          empty,
   output logic                          pop,
   input  coord_t                        node_x,
   input  coord_t                        node_y,
   input  logic [NOC_NUM_PORTS-1:0]      out_stall,
   output flit_u                         out_flit,
   output logic [NOC_NUM_PORTS-1:0]      out_valid
);

   out_port_e                    route_port;
   out_port_e                    sel_port;
   out_port_e                    hold_port;
   logic                         hold_active;
   logic [NOC_NUM_PORTS-1:0]     sel_onehot;
   logic                         head_is_hdr;
   logic                         head_is_last;
   logic                         consume;
   logic                         out_free;

   //////////////////////////////////////////////////
   // route lookup for the fifo head
   //////////////////////////////////////////////////

   xy_route_unit i_xy_route_unit (
      .dest_x (head_flit.hdr.dest_x),
      .dest_y (head_flit.hdr.dest_y),
      .node_x (node_x),
      .node_y (node_y),
      .port   (route_port)
   );

   assign head_is_hdr  = (head_flit.hdr.kind == FLIT_HEADER) ||
                         (head_flit.hdr.kind == FLIT_HEAD_TAIL);
   assign head_is_last = (head_flit.body.kind == FLIT_TAIL) ||
                         (head_flit.body.kind == FLIT_HEAD_TAIL);

   // openers route, the rest follow the held port
   assign sel_port = head_is_hdr ? route_port : hold_port;

   // code to one-hot, bit i is code i+1
   always_comb begin
      sel_onehot = '0;
      for (int i = 0; i < NOC_NUM_PORTS; i++) begin
         if (int'(sel_port) == i + 1) begin
            sel_onehot[i] = 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // handshake with the receivers
   //////////////////////////////////////////////////

   // taken when its port is not stalled
   assign consume  = |(out_valid & ~out_stall);
   assign out_free = ~|out_valid | consume;
   assign pop      = !empty && out_free;

   //////////////////////////////////////////////////
   // output and wormhole registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid   <= '0;
         hold_port   <= PORT_LOCAL;
         hold_active <= 1'b0;
      end else if (pop) begin
         out_valid <= sel_onehot;
         if (head_is_last) begin
            // tail or head_tail frees the port
            hold_active <= 1'b0;
         end else if (head_is_hdr) begin
            hold_active <= 1'b1;
            hold_port   <= route_port;
         end
      end else if (consume) begin
         out_valid <= '0;
      end
   end

   // flit word, loaded with each pop
   always_ff @(posedge clk) begin
      if (pop) begin
         out_flit <= head_flit;
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   a_valid_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(out_valid))
      else $error("output_steer: more than one out_valid bit");

   // stalled flit stays put
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      |(out_valid & out_stall) |=> (out_valid == $past(out_valid)) &&
                                   (out_flit == $past(out_flit)))
      else $error("output_steer: flit changed under stall");

   // body and tail only inside a packet, ingress framing guarantees it
   a_body_in_worm: assert property (@(posedge clk) disable iff (rst)
      (pop && !head_is_hdr) |-> hold_active)
      else $error("output_steer: body flit with no held port");

endmodule

// ==== hdl/router_node.sv ====
`timescale 1ns/100ps

`include "noc_cfg.svh"

module router_node import noc_flit_pkg::*, noc_port_pkg::*; #(
   parameter coord_t NODE_X = `NOC_NODE_X,
   parameter coord_t NODE_Y = `NOC_NODE_Y
) (
   input  logic                          clk,
   input  logic                          rst,
   input  flit_u                         in_flit,
   input  logic                          in_valid,
   output logic                          in_full,
   output logic                          drop,
   output flit_u                         out_flit,
   output logic [NOC_NUM_PORTS-1:0]      out_valid,
   input  logic [NOC_NUM_PORTS-1:0]      out_stall
);

   // ingress to fifo
   flit_u                                stage_flit;
   logic                                 stage_push;
   logic [$clog2(`NOC_FIFO_DEPTH):0]     fifo_count;

   // fifo to steering
   flit_u                                head_flit;
   logic                                 fifo_empty;
   logic                                 pop;

   //////////////////////////////////////////////////
   // input side
   //////////////////////////////////////////////////

   flit_ingress i_flit_ingress (
      .clk        (clk),
      .rst        (rst),
      .in_flit    (in_flit),
      .in_valid   (in_valid),
      .fifo_count (fifo_count),
      .in_full    (in_full),
      .drop       (drop),
      .stage_flit (stage_flit),
      .stage_push (stage_push)
   );

   flit_fifo i_flit_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (stage_push),
      .push_flit (stage_flit),
      .pop       (pop),
      .head_flit (head_flit),
      .empty     (fifo_empty),
      .count     (fifo_count)
   );

   //////////////////////////////////////////////////
   // output side
   //////////////////////////////////////////////////

   output_steer i_output_steer (
      .clk       (clk),
      .rst       (rst),
      .head_flit (head_flit),
      .empty     (fifo_empty),
      .pop       (pop),
      .node_x    (NODE_X),
      .node_y    (NODE_Y),
      .out_stall (out_stall),
      .out_flit  (out_flit),
      .out_valid (out_valid)
   );

endmodule

// ==== tests/router_scoreboard.sv ====
`timescale 1ns/100ps

`include "noc_cfg.svh"

module router_scoreboard import noc_flit_pkg::*, noc_port_pkg::*; #(
   parameter int NODE_X = `NOC_NODE_X,
   parameter int NODE_Y = `NOC_NODE_Y
) (
   input  logic                          clk,
   input  logic                          rst,
   input  flit_u                         in_flit,
   input  logic                          in_valid,
   input  logic                          in_full,
   input  logic                          drop,
   input  flit_u                         out_flit,
   input  logic [NOC_NUM_PORTS-1:0]      out_valid,
   input  logic [NOC_NUM_PORTS-1:0]      out_stall,
   output int                            pending
);

   // expected port on top, flit word below
   localparam int ENTRY_W = NOC_NUM_PORTS + `NOC_FLIT_W;

   logic [ENTRY_W-1:0]           exp_q [$];
   flit_u                        exp_head;
   logic [NOC_NUM_PORTS-1:0]     exp_port;
   logic [NOC_NUM_PORTS-1:0]     worm_port;
   logic                         in_pkt;
   logic                         exp_drop;
   logic                         rst_q = 1'b0;
   logic                         consume;

   int err_data = 0;
   int err_drop = 0;
   int err_onehot = 0;
   int err_hold = 0;
   int err_occ = 0;
   int err_reset = 0;

   // xy rule seen from this node, bit i is port code i+1
   function automatic logic [NOC_NUM_PORTS-1:0] xy_port(input int dest_x, input int dest_y);
      int xdiff;
      int ydiff;
      int code;
      xdiff = dest_x - NODE_X;
      ydiff = dest_y - NODE_Y;
      if (xdiff > 0) code = 2;
      else if (xdiff < 0) code = 4;
      else if (ydiff > 0) code = 5;
      else if (ydiff < 0) code = 3;
      else code = 1;
      return NOC_NUM_PORTS'(1) << (code - 1);
   endfunction

   // a receiver takes the flit when its port is not stalled
   assign consume = |(out_valid & ~out_stall);

   always @(posedge clk) begin
      rst_q <= rst;
   end

   //////////////////////////////////////////////////
   // reference model, framing and expected queue
   //////////////////////////////////////////////////

   always @(posedge clk) begin : model
      logic                      opener;
      logic                      accept;
      logic [NOC_NUM_PORTS-1:0]  port;
      logic [ENTRY_W-1:0]        entry;
      opener = (in_flit.hdr.kind == FLIT_HEADER) || (in_flit.hdr.kind == FLIT_HEAD_TAIL);
      // openers only outside a packet, the rest only inside
      accept = in_valid && !in_full && (opener ? !in_pkt : in_pkt);
      if (rst) begin
         exp_q.delete();
         in_pkt = 1'b0;
         exp_drop <= 1'b0;
      end else begin
         if (consume && (exp_q.size() != 0)) begin
            void'(exp_q.pop_front());
         end
         exp_drop <= in_valid && !accept;
         if (accept) begin
            if (opener) begin
               port = xy_port(int'(in_flit.hdr.dest_x), int'(in_flit.hdr.dest_y));
               worm_port = port;
               in_pkt = (in_flit.hdr.kind == FLIT_HEADER);
            end else begin
               // body and tail ride the worm
               port = worm_port;
               if (in_flit.body.kind == FLIT_TAIL) begin
                  in_pkt = 1'b0;
               end
            end
            exp_q.push_back({port, in_flit});
         end
      end
      pending <= exp_q.size();
      if (exp_q.size() != 0) begin
         entry = exp_q[0];
         exp_head <= entry[`NOC_FLIT_W-1:0];
         exp_port <= entry[ENTRY_W-1:`NOC_FLIT_W];
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   a_out_match: assert property (@(posedge clk) disable iff (rst)
      consume |-> (pending != 0) && (out_flit == exp_head) && (out_valid == exp_port))
      else begin
         err_data++;
         $display("** Error: %0t: out flit %h on ports %b, expected %h on %b", $time,
                  $sampled(out_flit), $sampled(out_valid), exp_head, exp_port);
      end

   a_drop: assert property (@(posedge clk) disable iff (rst) drop == exp_drop)
      else begin
         err_drop++;
         $display("** Error: %0t: drop is %b, expected %b", $time, $sampled(drop), exp_drop);
      end

   a_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(out_valid))
      else begin
         err_onehot++;
         $display("** Error: %0t: out_valid %b not one-hot", $time, $sampled(out_valid));
      end

   // stalled flit and its strobe stay put
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      |(out_valid & out_stall) |=> $stable(out_valid) && $stable(out_flit))
      else begin
         err_hold++;
         $display("** Error: %0t: output changed while its port was stalled", $time);
      end

   // in_full must stop the sender before this many flits pile up
   a_occupancy: assert property (@(posedge clk) disable iff (rst)
      pending <= `NOC_FIFO_DEPTH + 2)
      else begin
         err_occ++;
         $display("** Error: %0t: %0d flits held, in_full rose too late", $time, pending);
      end

   a_reset_quiet: assert property (@(posedge clk)
      rst_q |-> (out_valid == '0) && !drop && !in_full)
      else begin
         err_reset++;
         $display("** Error: %0t: outputs active during or right after reset", $time);
      end

endmodule

// ==== tests/tb_router_node.sv ====
`timescale 1ns/100ps

`include "noc_cfg.svh"

module tb_router_node import noc_flit_pkg::*, noc_port_pkg::*;;

   // a few hundred cycles of traffic, wide margin on top
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int STALL_NONE = 0;
   localparam int STALL_RAND = 1;
   localparam int STALL_ALL = 2;

   logic                         clk;
   logic                         rst;
   flit_u                        in_flit;
   logic                         in_valid;
   logic                         in_full;
   logic                         drop;
   flit_u                        out_flit;
   logic [NOC_NUM_PORTS-1:0]     out_valid;
   logic [NOC_NUM_PORTS-1:0]     out_stall;
   int                           pending;
   int                           seed = 32'h02eac22c;
   int                           stall_mode;
   int                           cycle_cnt;
   int                           err_stim;
   logic                         full_seen;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   router_node #(
      .NODE_X (coord_t'(`NOC_NODE_X)),
      .NODE_Y (coord_t'(`NOC_NODE_Y))
   ) i_router_node (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_full   (in_full),
      .drop      (drop),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_stall (out_stall)
   );

   router_scoreboard #(
      .NODE_X (`NOC_NODE_X),
      .NODE_Y (`NOC_NODE_Y)
   ) i_router_scoreboard (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_full   (in_full),
      .drop      (drop),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_stall (out_stall),
      .pending   (pending)
   );

   //////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////

   function automatic flit_u make_header(input flit_kind_e kind, input int dx, input int dy,
                                         input int payload);
      flit_u f;
      f.hdr.kind    = kind;
      f.hdr.dest_x  = coord_t'(dx);
      f.hdr.dest_y  = coord_t'(dy);
      f.hdr.payload = payload[9:0];
      return f;
   endfunction

   function automatic flit_u make_body(input flit_kind_e kind, input int payload);
      flit_u f;
      f.body.kind    = kind;
      f.body.payload = payload[13:0];
      return f;
   endfunction

   // one clock, inputs change 1 ns after the edge
   task automatic next_cycle();
      logic [31:0] rnd;
      @(posedge clk);
      #1;
      rnd = $random(seed);
      case (stall_mode)
         STALL_RAND: out_stall = rnd[4:0] & rnd[12:8];
         STALL_ALL:  out_stall = '1;
         default:    out_stall = '0;
      endcase
      if ((stall_mode == STALL_ALL) && in_full) begin
         full_seen = 1'b1;
      end
   endtask

   // back to back flits, optionally waiting out in_full
   task automatic offer(input flit_u f, input logic honor_full);
      next_cycle();
      while (honor_full && in_full) begin
         in_valid = 1'b0;
         next_cycle();
      end
      in_flit  = f;
      in_valid = 1'b1;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         next_cycle();
         in_valid = 1'b0;
      end
   endtask

   task automatic send_packet(input int len, input int dx, input int dy, input int tag);
      if (len == 1) begin
         offer(make_header(FLIT_HEAD_TAIL, dx, dy, tag), 1'b1);
      end else begin
         offer(make_header(FLIT_HEADER, dx, dy, tag), 1'b1);
         for (int i = 1; i < len - 1; i++) begin
            offer(make_body(FLIT_BODY, tag * 8 + i), 1'b1);
         end
         offer(make_body(FLIT_TAIL, tag * 8 + len - 1), 1'b1);
      end
   endtask

   // wait until every accepted flit has left
   task automatic drain();
      idle(1);
      while (pending != 0) begin
         idle(1);
      end
      idle(2);
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin : stimulus
      int rnd;
      int errors;
      rst = 1'b1;
      in_flit = '0;
      in_valid = 1'b0;
      out_stall = '0;
      stall_mode = STALL_NONE;
      full_seen = 1'b0;
      err_stim = 0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      idle(2);

      // single flit packets to every node of the mesh
      for (int dx = 0; dx < `NOC_X_NODES; dx++) begin
         for (int dy = 0; dy < `NOC_Y_NODES; dy++) begin
            send_packet(1, dx, dy, dx * 4 + dy);
         end
      end
      drain();

      // wormhole packets, east then north
      send_packet(5, 3, 3, 40);
      send_packet(3, 0, 0, 41);
      drain();

      // framing errors, only 102 and 105 get through
      offer(make_body(FLIT_BODY, 100), 1'b1);
      offer(make_body(FLIT_TAIL, 101), 1'b1);
      offer(make_header(FLIT_HEADER, 2, 1, 102), 1'b1);
      offer(make_header(FLIT_HEADER, 1, 1, 103), 1'b1);
      offer(make_header(FLIT_HEAD_TAIL, 1, 1, 104), 1'b1);
      offer(make_body(FLIT_TAIL, 105), 1'b1);
      drain();

      // random back-pressure
      stall_mode = STALL_RAND;
      repeat (40) begin
         rnd = $random(seed);
         send_packet(1 + (rnd & 3), (rnd >> 4) & 3, (rnd >> 8) & 3, (rnd >> 12) & 'h1f);
      end
      stall_mode = STALL_NONE;
      drain();

      // all ports stalled, sender ignores in_full
      stall_mode = STALL_ALL;
      idle(2);
      offer(make_header(FLIT_HEADER, 3, 0, 50), 1'b1);
      for (int i = 0; i < 10; i++) begin
         offer(make_body(FLIT_BODY, 200 + i), 1'b0);
      end
      stall_mode = STALL_NONE;
      offer(make_body(FLIT_TAIL, 210), 1'b1);
      drain();

      if (!full_seen) begin
         err_stim++;
         $display("in_full never rose while all output ports were stalled");
      end

      errors = i_router_scoreboard.err_data + i_router_scoreboard.err_drop +
               i_router_scoreboard.err_onehot + i_router_scoreboard.err_hold +
               i_router_scoreboard.err_occ + i_router_scoreboard.err_reset + err_stim;
      $display("errors: data %0d, drop %0d, onehot %0d, hold %0d, occupancy %0d, reset %0d, stimulus %0d",
               i_router_scoreboard.err_data, i_router_scoreboard.err_drop,
               i_router_scoreboard.err_onehot, i_router_scoreboard.err_hold,
               i_router_scoreboard.err_occ, i_router_scoreboard.err_reset, err_stim);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   //////////////////////////////////////////////////
   // watchdog
   //////////////////////////////////////////////////

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/noc_flit_pkg.sv
hdl/noc_port_pkg.sv
hdl/flit_ingress.sv
hdl/flit_fifo.sv
hdl/xy_route_unit.sv
hdl/output_steer.sv
hdl/router_node.sv
tests/router_scoreboard.sv
tests/tb_router_node.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_router_node
LINT_TOP   = router_node
FILELIST   = filelist.f
OBJDIR     = obj_dir
PASS_MSG   = TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
